// ==== common/apb_pkg.sv ====
// ********************
// APB bus package
// Bus widths, completer count and the address map
// ********************

`default_nettype none

package apb_pkg;

	// ********************
	// Bus widths
	// ********************
	localparam int addr_width = 12;
	localparam int data_width = 32;

	// Low address bits that select a register inside one window
	localparam int offset_width = 8;

	// ********************
	// Completers
	// ********************
	localparam int num_slaves = 2;
	localparam int slave_scratch = 0;
	localparam int slave_timer = 1;

	// ********************
	// Address map
	// ********************
	// Each completer owns one window of 0x100 bytes
	localparam logic [addr_width-1:0] scratch_base = 12'h000;
	localparam logic [addr_width-1:0] timer_base = 12'h100;
	localparam logic [addr_width-1:0] window_size = 12'h100;
	// Everything from 0x200 upward decodes to no completer

endpackage

`default_nettype wire

// ==== common/periph_pkg.sv ====
// ********************
// Peripheral package
// Register offsets of the scratch bank and the timer
// Timer control word layout
// ********************

`default_nettype none

package periph_pkg;

	// ********************
	// Scratch bank
	// ********************
	localparam int scratch_words = 4;
	localparam logic [apb_pkg::offset_width-1:0] scratch_off_0 = 8'h00;
	localparam logic [apb_pkg::offset_width-1:0] scratch_off_1 = 8'h04;
	localparam logic [apb_pkg::offset_width-1:0] scratch_off_2 = 8'h08;
	localparam logic [apb_pkg::offset_width-1:0] scratch_off_3 = 8'h0C;

	// ********************
	// Timer
	// ********************
	localparam logic [apb_pkg::offset_width-1:0] reg_ctrl = 8'h00;
	localparam logic [apb_pkg::offset_width-1:0] reg_compare = 8'h04;
	// Read only
	localparam logic [apb_pkg::offset_width-1:0] reg_count = 8'h08;
	// Match flag, write 1 to clear
	localparam logic [apb_pkg::offset_width-1:0] reg_status = 8'h0C;
	localparam int status_match_bit = 0;

	// Control word as raw bus data or as fields
	// Reserved bits always read as zero
	typedef union packed
	{
		logic [apb_pkg::data_width-1:0] raw;
		struct packed
		{
			logic [15:0] rsvd_31_16;
			logic [7:0] prescale;
			logic [4:0] rsvd_7_3;
			logic irq_en;
			logic auto_reload;
			logic enable;
		} fields;
	} timer_ctrl_u;

endpackage

`default_nettype wire

// ==== apb_splitter/onehot_mux.sv ====
// ********************
// One-hot multiplexer
// Picks one of num_data words by a one-hot select
// ********************

`timescale 1ns/100ps
`default_nettype none

module onehot_mux
#(
	parameter int data_bits = 32,
	parameter int num_data = 2
)
(
	// Word i sits at bits [i*data_bits +: data_bits]
	input wire [data_bits*num_data-1:0] data_list,
	input wire [num_data-1:0] select,
	output logic [data_bits-1:0] data_out
);

	// OR of all selected words
	// Empty select gives zero
	always_comb
	begin
		data_out = '0;
		for (int i = 0; i < num_data; i++)
		begin
			if (select[i])
			begin
				data_out = data_out | data_list[i*data_bits +: data_bits];
			end
		end
	end

endmodule

`default_nettype wire

// ==== apb_splitter/apb_splitter.sv ====
// ********************
// APB splitter
// Fans one requester out to the completers
// Merges read data, ready and error back into one reply
// ********************

`timescale 1ns/100ps
`default_nettype none

module apb_splitter
(
	// Requester side
	input wire psel,
	input wire penable,
	input wire [apb_pkg::addr_width-1:0] paddr,
	input wire pwrite,
	input wire [apb_pkg::data_width-1:0] pwdata,
	output logic [apb_pkg::data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,

	// From the address decoder
	input wire [apb_pkg::num_slaves-1:0] slave_sel,

	// Completer side
	output logic [apb_pkg::num_slaves-1:0] slv_psel,
	output logic slv_penable,
	output logic [apb_pkg::addr_width-1:0] slv_paddr,
	output logic slv_pwrite,
	output logic [apb_pkg::data_width-1:0] slv_pwdata,
	input wire [apb_pkg::num_slaves*apb_pkg::data_width-1:0] slv_prdata,
	input wire [apb_pkg::num_slaves-1:0] slv_pready,
	input wire [apb_pkg::num_slaves-1:0] slv_pslverr
);

	logic mux_pready;

	// ********************
	// Request path
	// ********************
	// Only the addressed completer sees psel
	assign slv_psel = psel ? slave_sel : '0;

	// Shared request signals go to every completer
	assign slv_penable = penable;
	assign slv_paddr = paddr;
	assign slv_pwrite = pwrite;
	assign slv_pwdata = pwdata;

	// ********************
	// Response path
	// ********************
	onehot_mux
	#(
		.data_bits(apb_pkg::data_width),
		.num_data(apb_pkg::num_slaves)
	)
	i_rdata_mux
	(
		.data_list(slv_prdata),
		.select(slave_sel),
		.data_out(prdata)
	);

	onehot_mux
	#(
		.data_bits(1),
		.num_data(apb_pkg::num_slaves)
	)
	i_ready_mux
	(
		.data_list(slv_pready),
		.select(slave_sel),
		.data_out(mux_pready)
	);

	// Unmapped accesses give zero here
	onehot_mux
	#(
		.data_bits(1),
		.num_data(apb_pkg::num_slaves)
	)
	i_slverr_mux
	(
		.data_list(slv_pslverr),
		.select(slave_sel),
		.data_out(pslverr)
	);

	// Unmapped address answers ready at once so the bus never hangs
	always_comb
	begin
		pready = 1'b0;
		if (psel)
		begin
			if (slave_sel == '0)
			begin
				pready = 1'b1;
			end
			else
			begin
				pready = mux_pready;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/apb_addr_decoder.sv ====
// ********************
// APB address decoder
// Maps the bus address onto a one-hot completer select
// ********************

`timescale 1ns/100ps
`default_nettype none

module apb_addr_decoder
(
	input wire [apb_pkg::addr_width-1:0] paddr,
	output logic [apb_pkg::num_slaves-1:0] slave_sel
);

	// True when addr falls inside the window starting at base
	function automatic logic in_window
	(
		input logic [apb_pkg::addr_width-1:0] addr,
		input logic [apb_pkg::addr_width-1:0] base
	);
		logic [apb_pkg::addr_width-1:0] rel;
		rel = addr - base;
		return (addr >= base) && (rel < apb_pkg::window_size);
	endfunction

	// Windows do not overlap so at most one bit is set
	always_comb
	begin
		slave_sel = '0;
		if (in_window(paddr, apb_pkg::scratch_base))
		begin
			slave_sel[apb_pkg::slave_scratch] = 1'b1;
		end
		if (in_window(paddr, apb_pkg::timer_base))
		begin
			slave_sel[apb_pkg::slave_timer] = 1'b1;
		end
		// No match leaves the select all zero
	end

endmodule

`default_nettype wire

// ==== verilog/scratch_regs.sv ====
// ********************
// Scratch register bank
// Four read/write words with zero wait states
// ********************

`timescale 1ns/100ps
`default_nettype none

module scratch_regs
(
	input wire clk,
	input wire rst_n,
	input wire psel,
	input wire penable,
	input wire [apb_pkg::addr_width-1:0] paddr,
	input wire pwrite,
	input wire [apb_pkg::data_width-1:0] pwdata,
	output logic [apb_pkg::data_width-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic access;
	logic [apb_pkg::offset_width-1:0] offset;
	logic [periph_pkg::scratch_words-1:0] word_hit;
	logic [apb_pkg::data_width-1:0] scratch_mem [periph_pkg::scratch_words];

	// Access phase of our own transfer
	assign access = psel & penable;

	// Word aligned offset inside the window
	assign offset = {paddr[apb_pkg::offset_width-1:2], 2'b00};

	// One-hot word decode
	// Offsets at 0x10 and above hit nothing
	always_comb
	begin
		word_hit = '0;
		case (offset)
			periph_pkg::scratch_off_0: word_hit[0] = 1'b1;
			periph_pkg::scratch_off_1: word_hit[1] = 1'b1;
			periph_pkg::scratch_off_2: word_hit[2] = 1'b1;
			periph_pkg::scratch_off_3: word_hit[3] = 1'b1;
			default: word_hit = '0;
		endcase
	end

	// Never stalls
	assign pready = 1'b1;
	assign pslverr = access & ~(|word_hit);

	// Read data only while we are addressed, zero otherwise
	always_comb
	begin
		prdata = '0;
		if (access && !pwrite)
		begin
			for (int i = 0; i < periph_pkg::scratch_words; i++)
			begin
				if (word_hit[i])
				begin
					prdata = scratch_mem[i];
				end
			end
		end
	end

	// Write lands on the completing edge
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < periph_pkg::scratch_words; i++)
			begin
				scratch_mem[i] <= '0;
			end
		end
		else if (access && pwrite)
		begin
			for (int i = 0; i < periph_pkg::scratch_words; i++)
			begin
				if (word_hit[i])
				begin
					scratch_mem[i] <= pwdata;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== timer/apb_timer.sv ====
// ********************
// APB interval timer
// Prescaled counter with compare, auto reload and interrupt
// Every access takes one wait state
// ********************

`timescale 1ns/100ps
`default_nettype none

module apb_timer
(
	input wire clk,
	input wire rst_n,
	input wire psel,
	input wire penable,
	input wire [apb_pkg::addr_width-1:0] paddr,
	input wire pwrite,
	input wire [apb_pkg::data_width-1:0] pwdata,
	output logic [apb_pkg::data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic irq
);

	periph_pkg::timer_ctrl_u ctrl;
	periph_pkg::timer_ctrl_u wr_view;
	periph_pkg::timer_ctrl_u ctrl_wdata;
	logic [apb_pkg::data_width-1:0] compare;
	logic [apb_pkg::data_width-1:0] count;
	logic [7:0] presc_cnt;
	logic status_match;
	logic wait_flag;
	logic access;
	logic wr_done;
	logic tick;
	logic hit;
	logic sel_ctrl;
	logic sel_compare;
	logic sel_status;
	logic bad_write;
	logic [apb_pkg::offset_width-1:0] offset;
	logic [apb_pkg::data_width-1:0] reg_rdata;

	// ********************
	// Bus side
	// ********************
	assign access = psel & penable;
	assign offset = paddr[apb_pkg::offset_width-1:0];

	// Low in the first access cycle and high in the second
	assign pready = wait_flag;
	assign wr_done = access & wait_flag & pwrite & ~bad_write;

	// Register decode and read mux
	always_comb
	begin
		sel_ctrl = 1'b0;
		sel_compare = 1'b0;
		sel_status = 1'b0;
		bad_write = 1'b0;
		reg_rdata = '0;
		case (offset)
			periph_pkg::reg_ctrl:
			begin
				sel_ctrl = 1'b1;
				reg_rdata = ctrl.raw;
			end
			periph_pkg::reg_compare:
			begin
				sel_compare = 1'b1;
				reg_rdata = compare;
			end
			// Count is read only
			periph_pkg::reg_count:
			begin
				bad_write = 1'b1;
				reg_rdata = count;
			end
			periph_pkg::reg_status:
			begin
				sel_status = 1'b1;
				reg_rdata[periph_pkg::status_match_bit] = status_match;
			end
			default: bad_write = 1'b1;
		endcase
	end

	assign prdata = (access && !pwrite) ? reg_rdata : '0;
	assign pslverr = access & pwrite & bad_write;

	// Keep only the defined control fields
	always_comb
	begin
		wr_view.raw = pwdata;
		ctrl_wdata.raw = '0;
		ctrl_wdata.fields.enable = wr_view.fields.enable;
		ctrl_wdata.fields.auto_reload = wr_view.fields.auto_reload;
		ctrl_wdata.fields.irq_en = wr_view.fields.irq_en;
		ctrl_wdata.fields.prescale = wr_view.fields.prescale;
	end

	// ********************
	// Counter
	// ********************
	// One tick every prescale+1 clocks while enabled
	assign tick = ctrl.fields.enable & (presc_cnt == ctrl.fields.prescale);
	assign hit = (count == compare);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wait_flag <= 1'b0;
			ctrl.raw <= '0;
			compare <= '0;
		end
		else
		begin
			wait_flag <= access & ~wait_flag;
			if (wr_done && sel_ctrl)
			begin
				ctrl <= ctrl_wdata;
			end
			if (wr_done && sel_compare)
			begin
				compare <= pwdata;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			presc_cnt <= '0;
			count <= '0;
			status_match <= 1'b0;
		end
		else
		begin
			if (!ctrl.fields.enable || tick)
			begin
				presc_cnt <= '0;
			end
			else
			begin
				presc_cnt <= presc_cnt + 8'd1;
			end
			// Wrap to zero on match only in auto reload mode
			if (tick)
			begin
				count <= (hit && ctrl.fields.auto_reload) ? '0 : count + 1'b1;
			end
			// A new match wins over a clear in the same cycle
			if (tick && hit)
			begin
				status_match <= 1'b1;
			end
			else if (wr_done && sel_status && pwdata[periph_pkg::status_match_bit])
			begin
				status_match <= 1'b0;
			end
		end
	end

	assign irq = status_match & ctrl.fields.irq_en;

endmodule

`default_nettype wire

// ==== verilog/apb_periph_top.sv ====
// ********************
// APB peripheral block
// Decoder and splitter in front of scratch bank and timer
// ********************

`timescale 1ns/100ps
`default_nettype none

module apb_periph_top
(
	input wire clk,
	input wire rst_n,
	input wire psel,
	input wire penable,
	input wire [apb_pkg::addr_width-1:0] paddr,
	input wire pwrite,
	input wire [apb_pkg::data_width-1:0] pwdata,
	output logic [apb_pkg::data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic irq
);

	localparam int dw = apb_pkg::data_width;

	logic [apb_pkg::num_slaves-1:0] slave_sel;
	logic [apb_pkg::num_slaves-1:0] slv_psel;
	logic slv_penable;
	logic [apb_pkg::addr_width-1:0] slv_paddr;
	logic slv_pwrite;
	logic [dw-1:0] slv_pwdata;
	logic [apb_pkg::num_slaves*dw-1:0] slv_prdata;
	logic [apb_pkg::num_slaves-1:0] slv_pready;
	logic [apb_pkg::num_slaves-1:0] slv_pslverr;

	apb_addr_decoder i_decoder
	(
		.paddr(paddr),
		.slave_sel(slave_sel)
	);

	apb_splitter i_splitter
	(
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.slave_sel(slave_sel),
		.slv_psel(slv_psel),
		.slv_penable(slv_penable),
		.slv_paddr(slv_paddr),
		.slv_pwrite(slv_pwrite),
		.slv_pwdata(slv_pwdata),
		.slv_prdata(slv_prdata),
		.slv_pready(slv_pready),
		.slv_pslverr(slv_pslverr)
	);

	// Completer slots follow the package indices
	scratch_regs i_scratch
	(
		.clk(clk),
		.rst_n(rst_n),
		.psel(slv_psel[apb_pkg::slave_scratch]),
		.penable(slv_penable),
		.paddr(slv_paddr),
		.pwrite(slv_pwrite),
		.pwdata(slv_pwdata),
		.prdata(slv_prdata[apb_pkg::slave_scratch*dw +: dw]),
		.pready(slv_pready[apb_pkg::slave_scratch]),
		.pslverr(slv_pslverr[apb_pkg::slave_scratch])
	);

	apb_timer i_timer
	(
		.clk(clk),
		.rst_n(rst_n),
		.psel(slv_psel[apb_pkg::slave_timer]),
		.penable(slv_penable),
		.paddr(slv_paddr),
		.pwrite(slv_pwrite),
		.pwdata(slv_pwdata),
		.prdata(slv_prdata[apb_pkg::slave_timer*dw +: dw]),
		.pready(slv_pready[apb_pkg::slave_timer]),
		.pslverr(slv_pslverr[apb_pkg::slave_timer]),
		.irq(irq)
	);

endmodule

`default_nettype wire

// ==== bench/apb_periph_assert.sv ====
// ********************
// Protocol checks for the APB peripheral block
// Bound to the top level
// ********************

`timescale 1ns/100ps
`default_nettype none

module apb_periph_assert
(
	input wire clk,
	input wire rst_n,
	input wire psel,
	input wire penable,
	input wire pready,
	input wire irq,
	input wire [apb_pkg::num_slaves-1:0] slave_sel,
	input wire [apb_pkg::num_slaves-1:0] slv_psel,
	input wire status_match
);

	// Number of failed assertions, read by the testbench at the end
	int fail_count = 0;

	// At most one completer sees psel
	slv_psel_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(slv_psel))
	else
	begin
		fail_count++;
		$error("slv_psel selects more than one completer");
	end

	// Interrupt only follows a pending match
	irq_needs_match: assert property (@(posedge clk) disable iff (!rst_n) irq |-> status_match)
	else
	begin
		fail_count++;
		$error("irq is high while status match is low");
	end

	// Unmapped access completes in its first access cycle
	unmapped_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable && slave_sel == '0) |-> pready)
	else
	begin
		fail_count++;
		$error("pready is low during an unmapped access");
	end

endmodule

bind apb_periph_top apb_periph_assert i_protocol_assert
(
	.clk(clk),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.irq(irq),
	.slave_sel(slave_sel),
	.slv_psel(slv_psel),
	.status_match(i_timer.status_match)
);

`default_nettype wire

// ==== bench/tb_apb_periph.sv ====
// ********************
// Testbench for the APB peripheral block
// Table-driven accesses, timer match and interrupt checks
// ********************

`timescale 1ns/100ps
`default_nettype none

module tb_apb_periph;

	localparam int aw = apb_pkg::addr_width;
	localparam int dw = apb_pkg::data_width;
	localparam time half_period = 50ns;
	localparam time drive_delay = 1ns;
	localparam int access_timeout = 16;
	localparam int irq_timeout = 200;
	localparam int poll_limit = 50;
	localparam logic [aw-1:0] t_ctrl = apb_pkg::timer_base + periph_pkg::reg_ctrl;
	localparam logic [aw-1:0] t_compare = apb_pkg::timer_base + periph_pkg::reg_compare;
	localparam logic [aw-1:0] t_count = apb_pkg::timer_base + periph_pkg::reg_count;
	localparam logic [aw-1:0] t_status = apb_pkg::timer_base + periph_pkg::reg_status;

	// Control bits that exist
	// enable 0, auto reload 1, irq enable 2, prescale 15:8
	localparam logic [dw-1:0] ctrl_defined_bits = 32'h0000_FF07;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic [aw-1:0] paddr;
	logic pwrite;
	logic [dw-1:0] pwdata;
	wire [dw-1:0] prdata;
	wire pready;
	wire pslverr;
	wire irq;
	integer seed;

	// ********************
	// Stimulus table
	// ********************
	logic tbl_write [$];
	logic [aw-1:0] tbl_addr [$];
	logic [dw-1:0] tbl_wdata [$];
	logic [dw-1:0] tbl_rdata [$];
	logic tbl_slverr [$];

	apb_periph_top i_dut
	(
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.irq(irq)
	);

	initial
	begin
		clk = 1'b0;
	end

	always
	begin
		#(half_period) clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "Testbench stopped at the first failure");
	endtask

	// ********************
	// Compare tasks
	// ********************
	task automatic check_rdata(input logic [aw-1:0] addr, input logic [dw-1:0] exp,
		input logic [dw-1:0] got);
		if (got !== exp)
		begin
			report_failure($sformatf("ERROR: prdata at paddr 0x%03h expected 0x%08h got 0x%08h",
				addr, exp, got));
		end
	endtask

	task automatic check_slverr(input logic [aw-1:0] addr, input logic exp, input logic got);
		if (got !== exp)
		begin
			report_failure($sformatf("ERROR: pslverr at paddr 0x%03h expected 0x%0h got 0x%0h",
				addr, exp, got));
		end
	endtask

	task automatic check_irq(input logic exp, input logic got);
		if (got !== exp)
		begin
			report_failure($sformatf("ERROR: irq expected 0x%0h got 0x%0h", exp, got));
		end
	endtask

	task automatic check_cycles(input logic [aw-1:0] addr, input int exp, input int got);
		if (got != exp)
		begin
			report_failure($sformatf(
				"ERROR: access cycles at paddr 0x%03h expected 0x%0h got 0x%0h",
				addr, exp, got));
		end
	endtask

	// Timer window costs one wait state
	// Scratch and unmapped space cost none
	function automatic int expected_cycles(input logic [aw-1:0] addr);
		if (addr >= apb_pkg::timer_base && addr < apb_pkg::timer_base + apb_pkg::window_size)
		begin
			return 2;
		end
		return 1;
	endfunction

	// Control word built through the field view
	function automatic logic [dw-1:0] ctrl_word(input logic enable, input logic auto_reload,
		input logic irq_en, input logic [7:0] prescale);
		periph_pkg::timer_ctrl_u ctrl;
		ctrl.raw = '0;
		ctrl.fields.enable = enable;
		ctrl.fields.auto_reload = auto_reload;
		ctrl.fields.irq_en = irq_en;
		ctrl.fields.prescale = prescale;
		return ctrl.raw;
	endfunction

	// Only the defined control bits read back
	function automatic logic [dw-1:0] ctrl_readback(input logic [dw-1:0] written);
		return written & ctrl_defined_bits;
	endfunction

	// ********************
	// APB access
	// ********************
	// Called and returns a small delay after a rising edge
	task automatic apb_access(input logic write, input logic [aw-1:0] addr,
		input logic [dw-1:0] wdata, output logic [dw-1:0] rdata, output logic slverr,
		output int cycles);
		logic done;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = write ? wdata : '0;
		@(posedge clk);
		#(drive_delay);
		penable = 1'b1;
		cycles = 0;
		done = 1'b0;
		while (!done)
		begin
			// Sample mid-cycle where the response has settled
			@(negedge clk);
			cycles++;
			if (pready === 1'b1)
			begin
				rdata = prdata;
				slverr = pslverr;
				done = 1'b1;
			end
			else if (cycles >= access_timeout)
			begin
				report_failure($sformatf(
					"Timeout: pready never rose during access to 0x%03h", addr));
			end
		end
		@(posedge clk);
		#(drive_delay);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic do_access(input logic write, input logic [aw-1:0] addr,
		input logic [dw-1:0] wdata, input logic [dw-1:0] exp_rdata, input logic exp_slverr);
		logic [dw-1:0] rdata;
		logic slverr;
		int cycles;
		apb_access(write, addr, wdata, rdata, slverr, cycles);
		check_rdata(addr, exp_rdata, rdata);
		check_slverr(addr, exp_slverr, slverr);
		check_cycles(addr, expected_cycles(addr), cycles);
	endtask

	task automatic add_entry(input logic write, input logic [aw-1:0] addr,
		input logic [dw-1:0] wdata, input logic [dw-1:0] rdata, input logic slverr);
		tbl_write.push_back(write);
		tbl_addr.push_back(addr);
		tbl_wdata.push_back(wdata);
		tbl_rdata.push_back(rdata);
		tbl_slverr.push_back(slverr);
	endtask

	task automatic build_table();
		logic [dw-1:0] words [periph_pkg::scratch_words];
		logic [dw-1:0] ctrl_raw;
		logic [dw-1:0] cmp_raw;
		for (int i = 0; i < periph_pkg::scratch_words; i++)
		begin
			words[i] = $random(seed);
			add_entry(1'b1, apb_pkg::scratch_base + 4 * i, words[i], '0, 1'b0);
		end
		for (int i = 0; i < periph_pkg::scratch_words; i++)
		begin
			add_entry(1'b0, apb_pkg::scratch_base + 4 * i, '0, words[i], 1'b0);
		end
		// Offsets past the bank fail and leave the words alone
		add_entry(1'b1, apb_pkg::scratch_base + 12'h010, $random(seed), '0, 1'b1);
		add_entry(1'b0, apb_pkg::scratch_base + 12'h010, '0, '0, 1'b1);
		add_entry(1'b0, apb_pkg::scratch_base + 12'h0FC, '0, '0, 1'b1);
		add_entry(1'b0, apb_pkg::scratch_base, '0, words[0], 1'b0);
		add_entry(1'b0, apb_pkg::scratch_base + 12'h00C, '0, words[3], 1'b0);
		// Unmapped space answers at once with zero
		add_entry(1'b1, 12'h300, $random(seed), '0, 1'b0);
		add_entry(1'b0, 12'h300, '0, '0, 1'b0);
		add_entry(1'b0, 12'hFFC, '0, '0, 1'b0);
		// Timer registers with the counter kept off
		ctrl_raw = $random(seed);
		ctrl_raw[0] = 1'b0;
		cmp_raw = $random(seed);
		add_entry(1'b1, t_ctrl, ctrl_raw, '0, 1'b0);
		add_entry(1'b0, t_ctrl, '0, ctrl_readback(ctrl_raw), 1'b0);
		add_entry(1'b1, t_compare, cmp_raw, '0, 1'b0);
		add_entry(1'b0, t_compare, '0, cmp_raw, 1'b0);
		add_entry(1'b1, t_count, $random(seed), '0, 1'b1);
		add_entry(1'b0, t_count, '0, '0, 1'b0);
		add_entry(1'b0, t_status, '0, '0, 1'b0);
		add_entry(1'b1, t_ctrl, '0, '0, 1'b0);
	endtask

	task automatic wait_for_irq();
		int waited;
		waited = 0;
		@(negedge clk);
		while (irq !== 1'b1)
		begin
			waited++;
			if (waited > irq_timeout)
			begin
				report_failure("Timeout: irq never rose after the timer was enabled");
			end
			@(negedge clk);
		end
		@(posedge clk);
		#(drive_delay);
	endtask

	// Poll status until match while irq stays low
	task automatic poll_status_match();
		logic [dw-1:0] rdata;
		logic slverr;
		int cycles;
		int polls;
		polls = 0;
		rdata = '0;
		while (rdata[periph_pkg::status_match_bit] !== 1'b1)
		begin
			polls++;
			if (polls > poll_limit)
			begin
				report_failure("Timeout: status match never set with the interrupt disabled");
			end
			apb_access(1'b0, t_status, '0, rdata, slverr, cycles);
			check_irq(1'b0, irq);
		end
	endtask

	// ********************
	// Main sequence
	// ********************
	initial
	begin
		seed = 92;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		paddr = '0;
		pwrite = 1'b0;
		pwdata = '0;
		repeat (10) @(posedge clk);
		#(drive_delay);
		rst_n = 1'b1;
		check_irq(1'b0, irq);

		build_table();
		for (int i = 0; i < tbl_addr.size(); i++)
		begin
			do_access(tbl_write[i], tbl_addr[i], tbl_wdata[i], tbl_rdata[i], tbl_slverr[i]);
		end

		// Match with interrupt, auto reload, no prescale
		do_access(1'b1, t_compare, 32'd5, '0, 1'b0);
		do_access(1'b1, t_ctrl, ctrl_word(1'b1, 1'b1, 1'b1, 8'h00), '0, 1'b0);
		wait_for_irq();
		do_access(1'b0, t_status, '0, 32'h1, 1'b0);
		check_irq(1'b1, irq);
		// Stop the counter so no new match races the clear
		do_access(1'b1, t_ctrl, ctrl_word(1'b0, 1'b0, 1'b1, 8'h00), '0, 1'b0);
		do_access(1'b1, t_status, 32'h1, '0, 1'b0);
		@(negedge clk);
		check_irq(1'b0, irq);
		@(posedge clk);
		#(drive_delay);
		do_access(1'b0, t_status, '0, '0, 1'b0);

		// Match with the interrupt masked
		do_access(1'b1, t_compare, 32'd3, '0, 1'b0);
		do_access(1'b1, t_ctrl, ctrl_word(1'b1, 1'b1, 1'b0, 8'h02), '0, 1'b0);
		poll_status_match();
		do_access(1'b1, t_ctrl, '0, '0, 1'b0);
		do_access(1'b0, t_status, '0, 32'h1, 1'b0);
		check_irq(1'b0, irq);

		if (i_dut.i_protocol_assert.fail_count == 0)
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
		else
		begin
			$display("Simulation finished: FAIL");
			$fatal(1, "Protocol assertions failed during the run");
		end
	end

endmodule

`default_nettype wire

// ==== all.f ====
common/apb_pkg.sv
common/periph_pkg.sv
apb_splitter/onehot_mux.sv
apb_splitter/apb_splitter.sv
verilog/apb_addr_decoder.sv
verilog/scratch_regs.sv
timer/apb_timer.sv
verilog/apb_periph_top.sv
bench/apb_periph_assert.sv
bench/tb_apb_periph.sv
